/* mips_params.svh */
// word width, register file size and program counter step macros
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// width of every datapath word, instruction and address
`define DATA_WIDTH 32

// register file geometry
`define REG_ADDR_WIDTH 5    // rs, rt and rd fields are 5 bits
`define NUM_REGS 32

// byte increment applied to the PC at each fetch
`define PC_STEP 4

`endif

/* mips_pkg.sv */
// control state, opcode, funct, ALU operation, ALU control and operand select types
package mips_pkg;

    // multi-cycle control states, one clock each
    typedef enum logic [3:0] {
        stFetch         = 4'd0,
        stDecode        = 4'd1,
        stMemAdr        = 4'd2,     // lw and sw address calculation
        stMemRead       = 4'd3,
        stMemWriteback  = 4'd4,
        stMemWrite      = 4'd5,
        stExecute       = 4'd6,     // R-type ALU step
        stAluWriteback  = 4'd7,
        stBranch        = 4'd8,
        stAddiExecute   = 4'd9,
        stAddiWriteback = 4'd10
    } stateT;

    // instruction bits 31:26
    typedef enum logic [5:0] {
        opRtype = 6'b000000,
        opLw    = 6'b100011,
        opSw    = 6'b101011,
        opBeq   = 6'b000100,
        opAddi  = 6'b001000
    } opcodeT;

    // R-type funct field, instruction bits 5:0
    typedef enum logic [5:0] {
        fnAdd = 6'b100000,
        fnSub = 6'b100010,
        fnAnd = 6'b100100,
        fnOr  = 6'b100101,
        fnSlt = 6'b101010
    } functT;

    // operation class requested by the control FSM
    typedef enum logic [1:0] {
        aluOpAdd   = 2'b00,
        aluOpSub   = 2'b01,
        aluOpFunct = 2'b10      // look at the funct field
    } aluOpT;

    // ALU control, bit 2 set means the B operand is inverted
    typedef enum logic [2:0] {
        aluAnd = 3'b000,
        aluOr  = 3'b001,
        aluAdd = 3'b010,
        aluSub = 3'b110,
        aluSlt = 3'b111
    } aluCtrlT;

    // second ALU operand source
    typedef enum logic [1:0] {
        srcBReg      = 2'b00,
        srcBFour     = 2'b01,
        srcBImm      = 2'b10,
        srcBImmShift = 2'b11    // branch offset in bytes
    } srcBSelT;

endpackage

/* controlFsm.sv */
// multi-cycle control FSM: state register, next-state logic and per-state control outputs
`timescale 1ns/1ps

module controlFsm
    import mips_pkg::*;
(
    input  logic    Clk,
    input  logic    Reset,
    input  opcodeT  Opcode,
    output logic    IorD,
    output logic    IRWrite,
    output logic    PCWrite,
    output logic    Branch,
    output logic    PCSrc,
    output logic    RegDst,
    output logic    MemtoReg,
    output logic    RegWrite,
    output logic    MemWrite,
    output logic    ALUSrcA,
    output srcBSelT ALUSrcB,
    output aluOpT   AluOp
);

    stateT state, nextState;

    always_ff @(posedge Clk or posedge Reset) begin
        if (Reset) begin
            state <= stFetch;
        end else begin
            state <= nextState;
        end
    end

    // next state, decode and memAdr branch on the opcode
    always_comb begin
        case (state)
            stFetch:  nextState = stDecode;
            stDecode: begin
                case (Opcode)
                    opLw, opSw: nextState = stMemAdr;
                    opRtype:    nextState = stExecute;
                    opBeq:      nextState = stBranch;
                    opAddi:     nextState = stAddiExecute;
                    default:    nextState = stFetch;    // unknown opcode acts as a no-op
                endcase
            end
            stMemAdr: begin
                if (Opcode == opLw) begin
                    nextState = stMemRead;
                end else if (Opcode == opSw) begin
                    nextState = stMemWrite;
                end else begin
                    nextState = stFetch;
                end
            end
            stMemRead:     nextState = stMemWriteback;
            stExecute:     nextState = stAluWriteback;
            stAddiExecute: nextState = stAddiWriteback;
            default:       nextState = stFetch;   // all writeback, memWrite and branch states
        endcase
    end

    // control outputs, anything not named in a state stays inactive
    always_comb begin
        IorD     = 1'b0;
        IRWrite  = 1'b0;
        PCWrite  = 1'b0;
        Branch   = 1'b0;
        PCSrc    = 1'b0;
        RegDst   = 1'b0;
        MemtoReg = 1'b0;
        RegWrite = 1'b0;
        MemWrite = 1'b0;
        ALUSrcA  = 1'b0;
        ALUSrcB  = srcBReg;
        AluOp    = aluOpAdd;
        case (state)
            stFetch: begin
                IRWrite = 1'b1;
                PCWrite = 1'b1;         // PC <= PC + 4
                ALUSrcB = srcBFour;
            end
            stDecode: begin
                ALUSrcB = srcBImmShift; // precompute the branch target into ALUOut
            end
            stMemAdr, stAddiExecute: begin
                ALUSrcA = 1'b1;
                ALUSrcB = srcBImm;
            end
            stMemRead: IorD = 1'b1;
            stMemWriteback: begin
                MemtoReg = 1'b1;
                RegWrite = 1'b1;        // writes rt
            end
            stMemWrite: begin
                IorD     = 1'b1;
                MemWrite = 1'b1;
            end
            stExecute: begin
                ALUSrcA = 1'b1;
                AluOp   = aluOpFunct;
            end
            stAluWriteback: begin
                RegDst   = 1'b1;        // writes rd
                RegWrite = 1'b1;
            end
            stBranch: begin
                ALUSrcA = 1'b1;
                AluOp   = aluOpSub;
                Branch  = 1'b1;
                PCSrc   = 1'b1;
            end
            stAddiWriteback: RegWrite = 1'b1;
            default: ;
        endcase
    end

endmodule

/* programCounter.sv */
// program counter register with next-value select and branch-taken enable
`timescale 1ns/1ps
`include "mips_params.svh"

module programCounter (
    input  logic                   Clk,
    input  logic                   Reset,
    input  logic                   PCWrite,
    input  logic                   Branch,
    input  logic                   PCSrc,
    input  logic                   Zero,
    input  logic [`DATA_WIDTH-1:0] AluResult,
    input  logic [`DATA_WIDTH-1:0] AluOut,
    output logic [`DATA_WIDTH-1:0] Pc
);

    logic [`DATA_WIDTH-1:0] pcNext;
    logic                   pcEn;

    // AluResult holds PC+4 in fetch, AluOut holds the branch target in stBranch
    assign pcNext = PCSrc ? AluOut : AluResult;

    // taken beq when the operands compared equal
    assign pcEn = PCWrite | (Branch & Zero);

    always_ff @(posedge Clk or posedge Reset) begin
        if (Reset) begin
            Pc <= '0;               // first fetch from address 0
        end else if (pcEn) begin
            Pc <= pcNext;
        end
    end

endmodule

/* registerFile.sv */
// register file: two asynchronous read ports, one clocked write port, r0 reads as zero
`timescale 1ns/1ps
`include "mips_params.svh"

module registerFile (
    input  logic                       Clk,
    input  logic                       RegWrite,
    input  logic [`REG_ADDR_WIDTH-1:0] ReadAdr1,
    input  logic [`REG_ADDR_WIDTH-1:0] ReadAdr2,
    input  logic [`REG_ADDR_WIDTH-1:0] WriteAdr,
    input  logic [`DATA_WIDTH-1:0]     WriteData,
    output logic [`DATA_WIDTH-1:0]     ReadData1,
    output logic [`DATA_WIDTH-1:0]     ReadData2
);

    logic [`DATA_WIDTH-1:0] regs [`NUM_REGS];

    always_ff @(posedge Clk) begin
        if (RegWrite) begin
            regs[WriteAdr] <= WriteData;    // a write to r0 is masked on read
        end
    end

    // read ports
    assign ReadData1 = (ReadAdr1 != '0) ? regs[ReadAdr1] : '0;
    assign ReadData2 = (ReadAdr2 != '0) ? regs[ReadAdr2] : '0;

endmodule

/* aluUnit.sv */
// ALU decoder and ALU with and, or, add, sub, slt and the zero flag
`timescale 1ns/1ps
`include "mips_params.svh"

module aluUnit
    import mips_pkg::*;
(
    input  aluOpT                  AluOp,
    input  functT                  Funct,
    input  logic [`DATA_WIDTH-1:0] SrcA,
    input  logic [`DATA_WIDTH-1:0] SrcB,
    output logic [`DATA_WIDTH-1:0] AluResult,
    output logic                   Zero
);

    aluCtrlT                aluCtrl;
    logic                   subtract;
    logic [`DATA_WIDTH-1:0] srcBMod;
    logic [`DATA_WIDTH-1:0] sum;

    // decoder
    always_comb begin
        case (AluOp)
            aluOpAdd: aluCtrl = aluAdd;
            aluOpSub: aluCtrl = aluSub;
            default: begin
                case (Funct)
                    fnSub:   aluCtrl = aluSub;
                    fnAnd:   aluCtrl = aluAnd;
                    fnOr:    aluCtrl = aluOr;
                    fnSlt:   aluCtrl = aluSlt;
                    default: aluCtrl = aluAdd;  // add, and any unknown funct
                endcase
            end
        endcase
    end

    // a - b computed as a + ~b + 1
    assign subtract = (aluCtrl == aluSub) || (aluCtrl == aluSlt);
    assign srcBMod  = subtract ? ~SrcB : SrcB;
    assign sum      = SrcA + srcBMod + `DATA_WIDTH'(subtract);

    always_comb begin
        case (aluCtrl)
            aluAnd:  AluResult = SrcA & SrcB;
            aluOr:   AluResult = SrcA | SrcB;
            aluSlt:  AluResult = {{(`DATA_WIDTH-1){1'b0}}, sum[`DATA_WIDTH-1]};  // sign of a - b
            default: AluResult = sum;
        endcase
    end

    assign Zero = (AluResult == '0);

endmodule

/* datapath.sv */
// multi-cycle datapath: instruction, data, A, B and ALUOut registers, operand muxes, sign extension
`timescale 1ns/1ps
`include "mips_params.svh"

module datapath
    import mips_pkg::*;
(
    input  logic                   Clk,
    input  logic                   Reset,
    input  logic                   IorD,
    input  logic                   IRWrite,
    input  logic                   PCWrite,
    input  logic                   Branch,
    input  logic                   PCSrc,
    input  logic                   RegDst,
    input  logic                   MemtoReg,
    input  logic                   RegWrite,
    input  logic                   ALUSrcA,
    input  srcBSelT                ALUSrcB,
    input  aluOpT                  AluOp,
    input  logic [`DATA_WIDTH-1:0] ReadData,
    output logic [`DATA_WIDTH-1:0] Adr,
    output logic [`DATA_WIDTH-1:0] WriteData,
    output opcodeT                 Opcode
);

    logic [`DATA_WIDTH-1:0]     instr;
    logic [`DATA_WIDTH-1:0]     dataReg;
    logic [`DATA_WIDTH-1:0]     aReg;
    logic [`DATA_WIDTH-1:0]     bReg;
    logic [`DATA_WIDTH-1:0]     aluOut;
    logic [`DATA_WIDTH-1:0]     pc;
    logic [`DATA_WIDTH-1:0]     rd1;
    logic [`DATA_WIDTH-1:0]     rd2;
    logic [`REG_ADDR_WIDTH-1:0] writeReg;
    logic [`DATA_WIDTH-1:0]     regWriteData;
    logic [`DATA_WIDTH-1:0]     signImm;
    logic [`DATA_WIDTH-1:0]     srcA;
    logic [`DATA_WIDTH-1:0]     srcB;
    logic [`DATA_WIDTH-1:0]     aluResult;
    logic                       zero;

    // instruction register only loads in fetch
    always_ff @(posedge Clk) begin
        if (IRWrite) begin
            instr <= ReadData;
        end
    end

    // non-architectural registers, loaded every cycle
    always_ff @(posedge Clk) begin
        dataReg <= ReadData;
        aReg    <= rd1;
        bReg    <= rd2;
        aluOut  <= aluResult;
    end

    assign Opcode = opcodeT'(instr[31:26]);

    // rd for R-type, rt for lw and addi
    assign writeReg     = RegDst ? instr[15:11] : instr[20:16];
    assign regWriteData = MemtoReg ? dataReg : aluOut;

    registerFile regFile (
        .Clk       (Clk),
        .RegWrite  (RegWrite),
        .ReadAdr1  (instr[25:21]),
        .ReadAdr2  (instr[20:16]),
        .WriteAdr  (writeReg),
        .WriteData (regWriteData),
        .ReadData1 (rd1),
        .ReadData2 (rd2)
    );

    assign signImm = {{(`DATA_WIDTH-16){instr[15]}}, instr[15:0]};

    // ALU operands
    assign srcA = ALUSrcA ? aReg : pc;

    always_comb begin
        case (ALUSrcB)
            srcBReg:      srcB = bReg;
            srcBFour:     srcB = `DATA_WIDTH'(`PC_STEP);
            srcBImm:      srcB = signImm;
            srcBImmShift: srcB = {signImm[`DATA_WIDTH-3:0], 2'b00};
        endcase
    end

    aluUnit alu (
        .AluOp     (AluOp),
        .Funct     (functT'(instr[5:0])),
        .SrcA      (srcA),
        .SrcB      (srcB),
        .AluResult (aluResult),
        .Zero      (zero)
    );

    programCounter pcReg (
        .Clk       (Clk),
        .Reset     (Reset),
        .PCWrite   (PCWrite),
        .Branch    (Branch),
        .PCSrc     (PCSrc),
        .Zero      (zero),
        .AluResult (aluResult),
        .AluOut    (aluOut),
        .Pc        (pc)
    );

    // memory port, data address comes from ALUOut
    assign Adr       = IorD ? aluOut : pc;
    assign WriteData = bReg;

endmodule

/* mipsMulti.sv */
// top level of the multi-cycle core: control FSM and datapath on one memory port
`timescale 1ns/1ps
`include "mips_params.svh"

module mipsMulti
    import mips_pkg::*;
(
    input  logic                   Clk,
    input  logic                   Reset,
    input  logic [`DATA_WIDTH-1:0] ReadData,
    output logic [`DATA_WIDTH-1:0] Adr,
    output logic [`DATA_WIDTH-1:0] WriteData,
    output logic                   MemWrite
);

    logic    iorD, irWrite, pcWrite, branch, pcSrc;
    logic    regDst, memtoReg, regWrite, aluSrcA;
    srcBSelT aluSrcB;
    aluOpT   aluOp;
    opcodeT  opcode;

    controlFsm ctrl (
        .Clk      (Clk),
        .Reset    (Reset),
        .Opcode   (opcode),
        .IorD     (iorD),
        .IRWrite  (irWrite),
        .PCWrite  (pcWrite),
        .Branch   (branch),
        .PCSrc    (pcSrc),
        .RegDst   (regDst),
        .MemtoReg (memtoReg),
        .RegWrite (regWrite),
        .MemWrite (MemWrite),       // straight to the memory port
        .ALUSrcA  (aluSrcA),
        .ALUSrcB  (aluSrcB),
        .AluOp    (aluOp)
    );

    datapath dp (
        .Clk       (Clk),
        .Reset     (Reset),
        .IorD      (iorD),
        .IRWrite   (irWrite),
        .PCWrite   (pcWrite),
        .Branch    (branch),
        .PCSrc     (pcSrc),
        .RegDst    (regDst),
        .MemtoReg  (memtoReg),
        .RegWrite  (regWrite),
        .ALUSrcA   (aluSrcA),
        .ALUSrcB   (aluSrcB),
        .AluOp     (aluOp),
        .ReadData  (ReadData),
        .Adr       (Adr),
        .WriteData (WriteData),
        .Opcode    (opcode)
    );

endmodule

/* tb_mipsMulti.sv */
// testbench for mipsMulti: random program, memory model, ISA reference model and checks
`timescale 1ns/1ps
`include "mips_params.svh"

module tb_mipsMulti
    import mips_pkg::*;
();

    localparam int numInstr   = 200;
    localparam int finalIdx   = numInstr - 1;      // beq r0,r0,-1 self-loop
    localparam int dataBase   = 256;               // first data word
    localparam int memWords   = 512;
    localparam int cycleLimit = 5 * numInstr + 100;

    logic                   Clk;
    logic                   Reset;
    logic [`DATA_WIDTH-1:0] ReadData;
    logic [`DATA_WIDTH-1:0] Adr;
    logic [`DATA_WIDTH-1:0] WriteData;
    logic                   MemWrite;

    logic [`DATA_WIDTH-1:0] mem [memWords];        // memory seen by the DUT
    logic [`DATA_WIDTH-1:0] modelMem [memWords];   // ISA model copy
    logic [`DATA_WIDTH-1:0] modelRegs [`NUM_REGS];
    logic [`DATA_WIDTH-1:0] modelPc;
    int                     cycleCount;

    mipsMulti dut (
        .Clk       (Clk),
        .Reset     (Reset),
        .ReadData  (ReadData),
        .Adr       (Adr),
        .WriteData (WriteData),
        .MemWrite  (MemWrite)
    );

    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    // single port memory, word index from the byte address
    assign ReadData = mem[Adr[10:2]];

    always @(posedge Clk) begin
        if (MemWrite) begin
            mem[Adr[10:2]] <= WriteData;
        end
    end

    always @(posedge Clk) begin
        if (!Reset) begin
            cycleCount++;
            if (cycleCount > cycleLimit) begin
                $display("timeout: the core never reached the final loop in %0d cycles",
                         cycleLimit);
                $display("ERRORS FOUND");
                $fatal(1, "run stopped by the cycle limit");
            end
        end
    end

    task automatic checkWord(string name, logic [`DATA_WIDTH-1:0] actual,
                             logic [`DATA_WIDTH-1:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic checkBit(string name, logic actual, logic expected);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s: got %b, expected %b", $time, name, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic [`DATA_WIDTH-1:0] encodeR(logic [4:0] rs, logic [4:0] rt,
                                                       logic [4:0] rd, functT fn);
        return {opRtype, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [`DATA_WIDTH-1:0] encodeI(opcodeT op, logic [4:0] rs,
                                                       logic [4:0] rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // byte offset of a random data word, used with base r0
    function automatic logic [15:0] dataOffset();
        return 16'((dataBase + $urandom_range(0, 63)) * 4);
    endfunction

    // ISA meaning of the R-type functs, slt is the sign of a - b
    function automatic logic [`DATA_WIDTH-1:0] rtypeResult(functT fn,
                                                           logic [`DATA_WIDTH-1:0] a,
                                                           logic [`DATA_WIDTH-1:0] b);
        logic [`DATA_WIDTH-1:0] diff;
        diff = a - b;
        case (fn)
            fnSub:   return diff;
            fnAnd:   return a & b;
            fnOr:    return a | b;
            fnSlt:   return {{(`DATA_WIDTH-1){1'b0}}, diff[`DATA_WIDTH-1]};
            default: return a + b;
        endcase
    endfunction

    task automatic setRegister(logic [4:0] idx, logic [`DATA_WIDTH-1:0] value);
        if (idx != 5'd0) begin
            modelRegs[idx] = value;     // r0 stays zero
        end
    endtask

    task automatic buildProgram();
        int         kind;
        int         fnSel;
        int         maxOff;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        functT      fn;
        for (int a = 0; a < memWords; a++) begin
            mem[a] = a * 32'h9E37_79B1 + 32'h1357_0000;
        end
        // r1 to r7 get defined values first
        for (int i = 0; i < 7; i++) begin
            mem[i] = encodeI(opAddi, 5'd0, 5'(i + 1), 16'($urandom));
        end
        for (int i = 7; i < finalIdx; i++) begin
            rs   = 5'($urandom_range(1, 7));
            rt   = 5'($urandom_range(1, 7));
            rd   = 5'($urandom_range(1, 7));
            kind = $urandom_range(0, 4);
            case (kind)
                0: begin
                    fnSel = $urandom_range(0, 4);
                    case (fnSel)
                        0:       fn = fnAdd;
                        1:       fn = fnSub;
                        2:       fn = fnAnd;
                        3:       fn = fnOr;
                        default: fn = fnSlt;
                    endcase
                    mem[i] = encodeR(rs, rt, rd, fn);
                end
                1: mem[i] = encodeI(opAddi, rs, rt, 16'($urandom));
                2: mem[i] = encodeI(opLw, 5'd0, rt, dataOffset());
                3: mem[i] = encodeI(opSw, 5'd0, 5'($urandom_range(0, 7)), dataOffset());
                default: begin
                    maxOff = (finalIdx - 1 - i < 3) ? finalIdx - 1 - i : 3;
                    if ($urandom_range(0, 1) == 1) begin
                        rt = rs;                // taken branch
                    end
                    mem[i] = encodeI(opBeq, rs, rt, 16'($urandom_range(0, maxOff)));
                end
            endcase
        end
        mem[finalIdx] = encodeI(opBeq, 5'd0, 5'd0, 16'hFFFF);
    endtask

    initial begin
        logic [`DATA_WIDTH-1:0] instr;
        logic [`DATA_WIDTH-1:0] signImm;
        logic [`DATA_WIDTH-1:0] srcA;
        logic [`DATA_WIDTH-1:0] srcB;
        logic [`DATA_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0] nextPc;
        logic [4:0]             rs;
        logic [4:0]             rt;
        logic [4:0]             rd;
        opcodeT                 op;
        int                     nCycles;
        int                     seedVal;
        bit                     finalSeen;
        bit                     done;
        Reset      = 1'b1;
        cycleCount = 0;
        seedVal    = $urandom(71);
        buildProgram();
        for (int a = 0; a < memWords; a++) begin
            modelMem[a] = mem[a];
        end
        for (int r = 0; r < `NUM_REGS; r++) begin
            modelRegs[r] = '0;
        end
        modelPc   = '0;
        finalSeen = 1'b0;
        done      = 1'b0;
        repeat (4) @(posedge Clk);
        #1 Reset = 1'b0;

        // the first pass through the loop checks the fetch at address 0 after reset
        while (!done) begin
            @(negedge Clk);
            checkWord("Adr", Adr, modelPc);
            checkBit("MemWrite", MemWrite, 1'b0);
            if (modelPc == finalIdx * 4) begin
                done      = finalSeen;      // second visit proves the self-loop
                finalSeen = 1'b1;
            end
            if (!done) begin
                instr   = modelMem[modelPc[10:2]];
                op      = opcodeT'(instr[31:26]);
                rs      = instr[25:21];
                rt      = instr[20:16];
                rd      = instr[15:11];
                signImm = {{(`DATA_WIDTH-16){instr[15]}}, instr[15:0]};
                srcA    = modelRegs[rs];
                srcB    = modelRegs[rt];
                addr    = srcA + signImm;
                nextPc  = modelPc + `PC_STEP;
                case (op)
                    opLw: begin
                        nCycles = 5;
                        setRegister(rt, modelMem[addr[10:2]]);
                    end
                    opSw: begin
                        nCycles = 4;
                        modelMem[addr[10:2]] = srcB;
                    end
                    opRtype: begin
                        nCycles = 4;
                        setRegister(rd, rtypeResult(functT'(instr[5:0]), srcA, srcB));
                    end
                    opAddi: begin
                        nCycles = 4;
                        setRegister(rt, srcA + signImm);
                    end
                    opBeq: begin
                        nCycles = 3;
                        if (srcA == srcB) begin
                            nextPc = nextPc + (signImm << 2);
                        end
                    end
                    default: nCycles = 2;       // fetch and decode only
                endcase
                for (int c = 2; c <= nCycles; c++) begin
                    @(negedge Clk);
                    if (op == opSw && c == nCycles) begin
                        checkBit("MemWrite", MemWrite, 1'b1);
                        checkWord("Adr", Adr, addr);
                        checkWord("WriteData", WriteData, srcB);
                    end else begin
                        checkBit("MemWrite", MemWrite, 1'b0);
                    end
                end
                modelPc = nextPc;
            end
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* mipsMulti.f */
+incdir+.
mips_pkg.sv
controlFsm.sv
programCounter.sv
registerFile.sv
aluUnit.sv
datapath.sv
mipsMulti.sv
tb_mipsMulti.sv
